//--- common/lsq_pkg.sv
// Shared definitions for the memory stage
// Queue and data memory sizes, vector typedefs
// Memory operation enum, instruction and queue entry structs
// Writeback record and APB request and response structs

`default_nettype none

package lsq_pkg;

    // Queue geometry
    localparam int unsigned LSQ_ENTRIES = 8;
    localparam int unsigned LSQ_IDX_W   = 3;   // log2 of LSQ_ENTRIES

    // Data memory geometry
    localparam int unsigned MEM_WORDS   = 64;  // Doublewords
    localparam int unsigned PADDR_W     = 12;  // Byte address on APB

    // Plain vectors with a meaning
    typedef logic [63:0]          bus64_t;     // Operand or data value
    typedef logic [LSQ_IDX_W-1:0] lsq_idx_t;   // Slot index
    typedef logic [LSQ_IDX_W:0]   lsq_cnt_t;   // Occupancy, one bit wider
    typedef logic [4:0]           reg_addr_t;  // Destination register
    typedef logic [PADDR_W-1:0]   paddr_t;     // APB byte address

    // Supported memory operations
    typedef enum logic [1:0] {
        MEM_LD = 2'd0,  // Load doubleword
        MEM_SD = 2'd1,  // Store doubleword
        MEM_LW = 2'd2,  // Load word, sign extended
        MEM_SW = 2'd3   // Store word
    } mem_op_t;

    // One memory instruction from register read
    typedef struct packed {
        logic      valid;
        mem_op_t   op;
        reg_addr_t rd;
        bus64_t    imm;   // Offset added to rs1
    } mem_instr_t;

    // One queue slot, also the queue head output
    typedef struct packed {
        mem_instr_t instr;
        bus64_t     rs1;  // Base address
        bus64_t     rs2;  // Store data
    } lsq_entry_t;

    // Writeback record of a finished access
    typedef struct packed {
        logic      valid;
        logic      is_store;
        logic      err;   // Access outside the memory
        reg_addr_t rd;
        bus64_t    data;  // Load result, zero for stores
    } wb_result_t;

    // APB master side, driven by the access unit
    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        paddr_t     paddr;
        bus64_t     pwdata;
        logic [7:0] pstrb;  // One bit per byte lane
    } apb_req_t;

    // APB completer side, driven by the data memory
    typedef struct packed {
        logic   pready;
        bus64_t prdata;
        logic   pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- lsq/load_store_queue.sv
// In-order load/store queue
// Circular buffer with a registered copy of the oldest entry
// Bypass of a new entry to the head when the queue is empty
// Tail index output, full and empty flags, flush

`default_nettype none

module load_store_queue (
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    input  wire logic                flush_i,      // Drop all queued entries
    input  wire lsq_pkg::lsq_entry_t entry_i,      // New entry from register read
    input  wire logic                pop_i,        // Access unit wants the head
    output lsq_pkg::lsq_entry_t      head_o,       // Zero unless a pop is granted
    output lsq_pkg::lsq_idx_t        entry_idx_o,  // Tail of the previous cycle
    output logic                     full_o,
    output logic                     empty_o
);

    // Slot storage
    lsq_pkg::lsq_entry_t slot_q [lsq_pkg::LSQ_ENTRIES];
    lsq_pkg::lsq_entry_t first_q;  // Oldest entry, read without the array

    // Pointers
    lsq_pkg::lsq_idx_t head_q;  // Slot after the oldest entry
    lsq_pkg::lsq_idx_t tail_q;  // Next free slot
    lsq_pkg::lsq_cnt_t cnt_q;   // Entries held

    logic write_en;  // Entry accepted this cycle
    logic read_en;   // Pop granted this cycle
    logic bypass;    // New entry goes straight to the head

    // Also full while in reset or flushing
    assign full_o = (cnt_q == lsq_pkg::lsq_cnt_t'(lsq_pkg::LSQ_ENTRIES)) | flush_i | ~rstn_i;

    assign write_en = entry_i.instr.valid & ~full_o;

    // Pop needs a stored entry or one arriving now
    assign read_en = pop_i & ~flush_i & ((cnt_q != '0) | write_en);

    assign bypass  = (cnt_q == '0) & write_en;
    assign empty_o = (cnt_q == '0) & ~write_en;

    // Head output
    always_comb begin
        if (!read_en) begin
            head_o = '0;             // Nothing granted
        end else if (bypass) begin
            head_o = entry_i;        // Empty queue passes through
        end else begin
            head_o = first_q;
        end
    end

    // Array write and first entry refill
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            slot_q[tail_q] <= entry_i;
        end
        if (read_en && (cnt_q > lsq_pkg::lsq_cnt_t'(1))) begin
            first_q <= slot_q[head_q];  // Next oldest moves up
        end else if (write_en && ((cnt_q == '0) ||
                                  ((cnt_q == lsq_pkg::lsq_cnt_t'(1)) && read_en))) begin
            first_q <= entry_i;         // New entry becomes the oldest
        end
    end

    // Pointer and count update
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= lsq_pkg::lsq_idx_t'(1);  // One past the slot of first_q
            tail_q <= '0;
            cnt_q  <= '0;
        end else if (flush_i) begin
            head_q <= lsq_pkg::lsq_idx_t'(1);
            tail_q <= '0;
            cnt_q  <= '0;
        end else begin
            head_q <= head_q + lsq_pkg::lsq_idx_t'(read_en);
            tail_q <= tail_q + lsq_pkg::lsq_idx_t'(write_en);
            cnt_q  <= cnt_q + lsq_pkg::lsq_cnt_t'(write_en) - lsq_pkg::lsq_cnt_t'(read_en);
        end
    end

    // Tail index delayed by one cycle
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            entry_idx_o <= '0;
        end else begin
            entry_idx_o <= tail_q;
        end
    end

    // Occupancy bound
    a_cnt_bound: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        cnt_q <= lsq_pkg::lsq_cnt_t'(lsq_pkg::LSQ_ENTRIES)
    ) else $error("LSQ count above capacity");

    // A full queue keeps its tail in place
    a_no_write_full: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        ((cnt_q == lsq_pkg::lsq_cnt_t'(lsq_pkg::LSQ_ENTRIES)) && !flush_i) |=>
            $stable(tail_q)
    ) else $error("LSQ write accepted while full");

    // Granted pop always hands over a real entry
    a_pop_nonempty: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        read_en |-> head_o.instr.valid
    ) else $error("LSQ pop granted while empty");

endmodule

`default_nettype wire

//--- lsq/lsq_access_unit.sv
// Memory access unit behind the load/store queue
// Pops the head, computes rs1 plus imm, runs one APB transfer
// Word placement and strobes, load sign extension
// Registered writeback that a flush drops

`default_nettype none

module lsq_access_unit (
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    input  wire logic                flush_i,
    input  wire lsq_pkg::lsq_entry_t head_i,     // Granted queue head
    output logic                     pop_o,
    output lsq_pkg::apb_req_t        apb_req_o,
    input  wire lsq_pkg::apb_rsp_t   apb_rsp_i,
    output lsq_pkg::wb_result_t      wb_o
);

    typedef enum logic [1:0] {
        ST_IDLE,    // Pop and latch
        ST_SETUP,   // psel, no penable
        ST_ACCESS   // Wait for pready
    } acc_state_e;

    acc_state_e state_q;

    // Latched instruction
    lsq_pkg::mem_instr_t instr_q;
    lsq_pkg::bus64_t     rs2_q;
    lsq_pkg::paddr_t     addr_q;
    lsq_pkg::bus64_t     eff_addr;  // Full width rs1 plus imm

    logic                flushed_q;  // Flush seen during this transfer
    lsq_pkg::wb_result_t wb_q;

    logic            is_store;
    logic            is_word;
    logic            upper;     // Word in bits 63:32
    logic [31:0]     ld_half;
    lsq_pkg::bus64_t ld_data;
    logic            take;      // Valid head latched

    assign pop_o    = (state_q == ST_IDLE);
    assign take     = pop_o & head_i.instr.valid;
    assign eff_addr = head_i.rs1 + head_i.instr.imm;

    assign is_store = (instr_q.op == lsq_pkg::MEM_SD) | (instr_q.op == lsq_pkg::MEM_SW);
    assign is_word  = (instr_q.op == lsq_pkg::MEM_LW) | (instr_q.op == lsq_pkg::MEM_SW);
    assign upper    = addr_q[2];

    // Request fields come from latched state only
    always_comb begin
        apb_req_o.psel    = (state_q != ST_IDLE);
        apb_req_o.penable = (state_q == ST_ACCESS);
        apb_req_o.pwrite  = is_store;
        apb_req_o.paddr   = addr_q;
        if (is_word) begin
            apb_req_o.pwdata = {2{rs2_q[31:0]}};           // Same word on both lanes
            apb_req_o.pstrb  = upper ? 8'hf0 : 8'h0f;
        end else begin
            apb_req_o.pwdata = rs2_q;
            apb_req_o.pstrb  = 8'hff;
        end
        if (!is_store) begin
            apb_req_o.pstrb = '0;  // Reads carry no strobes
        end
    end

    // Load result shaping
    always_comb begin
        ld_half = upper ? apb_rsp_i.prdata[63:32] : apb_rsp_i.prdata[31:0];
        if (is_store) begin
            ld_data = '0;
        end else if (is_word) begin
            ld_data = {{32{ld_half[31]}}, ld_half};  // Sign extend
        end else begin
            ld_data = apb_rsp_i.prdata;
        end
    end

    // Instruction latch
    always_ff @(posedge clk_i) begin
        if (take) begin
            instr_q <= head_i.instr;
            rs2_q   <= head_i.rs2;
            addr_q  <= eff_addr[lsq_pkg::PADDR_W-1:0];  // Upper bits dropped
        end
    end

    // Transfer FSM and writeback
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= ST_IDLE;
            flushed_q <= 1'b0;
            wb_q      <= '0;
        end else begin
            wb_q.valid <= 1'b0;  // One cycle pulse
            case (state_q)
                ST_IDLE: begin
                    flushed_q <= 1'b0;
                    if (take) begin
                        state_q <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    state_q <= ST_ACCESS;
                end
                ST_ACCESS: begin
                    if (apb_rsp_i.pready) begin
                        state_q       <= ST_IDLE;
                        wb_q.valid    <= ~(flushed_q | flush_i);  // Drop flushed work
                        wb_q.is_store <= is_store;
                        wb_q.err      <= apb_rsp_i.pslverr;
                        wb_q.rd       <= instr_q.rd;
                        wb_q.data     <= ld_data;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
            if (flush_i && (state_q != ST_IDLE)) begin
                flushed_q <= 1'b1;
            end
        end
    end

    assign wb_o = wb_q;

    // Request held steady until the transfer ends
    a_req_stable: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (apb_req_o.psel && !(apb_req_o.penable && apb_rsp_i.pready)) |=>
            $stable({apb_req_o.pwrite, apb_req_o.paddr, apb_req_o.pwdata, apb_req_o.pstrb})
    ) else $error("APB request changed during transfer");

    // penable only inside a selected transfer
    a_penable_psel: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        apb_req_o.penable |-> apb_req_o.psel
    ) else $error("APB penable without psel");

endmodule

`default_nettype wire

//--- hdl/apb_data_mem.sv
// APB data memory of doublewords
// Byte strobes on write, zero wait states
// Out of range addresses give pslverr and no write

`default_nettype none

module apb_data_mem (
    input  wire logic              clk_i,
    input  wire logic              rstn_i,
    input  wire lsq_pkg::apb_req_t apb_req_i,
    output lsq_pkg::apb_rsp_t      apb_rsp_o
);

    localparam int unsigned IDX_W = $clog2(lsq_pkg::MEM_WORDS);

    lsq_pkg::bus64_t  mem_q [lsq_pkg::MEM_WORDS];
    logic [IDX_W-1:0] word_idx;  // Doubleword select
    logic             access;    // ACCESS phase
    logic             in_range;

    assign access   = apb_req_i.psel & apb_req_i.penable;
    assign word_idx = apb_req_i.paddr[IDX_W+2:3];  // Byte offset ignored

    // Memory spans MEM_WORDS times 8 bytes from address zero
    assign in_range = (apb_req_i.paddr < lsq_pkg::paddr_t'(lsq_pkg::MEM_WORDS * 8));

    // Response, ready in the first ACCESS cycle
    always_comb begin
        apb_rsp_o.pready  = access;
        apb_rsp_o.pslverr = access & ~in_range;
        if (access && in_range && !apb_req_i.pwrite) begin
            apb_rsp_o.prdata = mem_q[word_idx];
        end else begin
            apb_rsp_o.prdata = '0;  // Zero on error or write
        end
    end

    // Byte lane writes
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < lsq_pkg::MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (access && apb_req_i.pwrite && in_range) begin
            for (int b = 0; b < 8; b++) begin
                if (apb_req_i.pstrb[b]) begin
                    mem_q[word_idx][8*b +: 8] <= apb_req_i.pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_stage_top.sv
// Memory stage top level
// Load/store queue, access unit and APB data memory

`default_nettype none

module mem_stage_top (
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    input  wire logic                flush_i,
    input  wire lsq_pkg::lsq_entry_t entry_i,      // From register read
    output lsq_pkg::lsq_idx_t        entry_idx_o,
    output logic                     full_o,
    output logic                     empty_o,
    output lsq_pkg::wb_result_t      wb_o          // To writeback
);

    lsq_pkg::lsq_entry_t head;     // Granted queue head
    logic                pop;
    lsq_pkg::apb_req_t   apb_req;
    lsq_pkg::apb_rsp_t   apb_rsp;

    // In-order buffer
    load_store_queue u_lsq (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .entry_i     (entry_i),
        .pop_i       (pop),
        .head_o      (head),
        .entry_idx_o (entry_idx_o),
        .full_o      (full_o),
        .empty_o     (empty_o)
    );

    // APB master
    lsq_access_unit u_acc (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .flush_i   (flush_i),
        .head_i    (head),
        .pop_o     (pop),
        .apb_req_o (apb_req),
        .apb_rsp_i (apb_rsp),
        .wb_o      (wb_o)
    );

    // APB completer
    apb_data_mem u_mem (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// Testbench clock and reset source
// 8 ns clock, active low reset held for 3 cycles

`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rstn_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned HALF_PERIOD = 4;  // ns
    localparam int unsigned RST_CYCLES  = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release just after an edge, like the other inputs
    initial begin
        rstn_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rstn_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/tb_mem_stage.sv
// Testbench of the memory stage top level
// Stimulus table applied in a loop, reference memory model
// Expected writeback queue checked in order against wb_o
// Flush, full and drain checks, tail index model, watchdog and result line

`default_nettype none

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;

    // One table row where flush rows carry no entry
    typedef struct packed {
        lsq_pkg::mem_op_t  op;
        lsq_pkg::reg_addr_t rd;
        lsq_pkg::bus64_t   rs1;
        lsq_pkg::bus64_t   rs2;
        lsq_pkg::bus64_t   imm;
        logic              gap;    // Drain before the next row
        logic              flush;  // Pulse flush_i instead of an entry
        logic              rnd;    // rs2 taken from $random
    } row_t;

    logic                clk_i;
    logic                rstn_i;
    logic                flush;
    lsq_pkg::lsq_entry_t entry;
    lsq_pkg::lsq_idx_t   entry_idx;
    logic                full_o;
    logic                empty_o;
    lsq_pkg::wb_result_t wb_o;

    row_t                table_q [$];
    lsq_pkg::wb_result_t exp_q [$];                  // In acceptance order
    lsq_pkg::bus64_t     ref_mem [lsq_pkg::MEM_WORDS];
    lsq_pkg::wb_result_t exp_wb;
    lsq_pkg::lsq_idx_t   tail_model  = '0;  // Queue tail in the current cycle
    lsq_pkg::lsq_idx_t   idx_exp     = '0;  // Tail of the previous cycle

    integer seed;
    int     val_errs    = 0;  // Wrong values
    int     other_errs  = 0;  // Protocol and count failures
    int     acc_cnt     = 0;
    int     drop_cnt    = 0;
    int     wb_cnt      = 0;
    int     flushed_cnt = 0;
    logic   saw_full    = 1'b0;

    tb_clock_gen u_clk (
        .clk_o  (clk_i),
        .rstn_o (rstn_i)
    );

    mem_stage_top DUT (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush),
        .entry_i     (entry),
        .entry_idx_o (entry_idx),
        .full_o      (full_o),
        .empty_o     (empty_o),
        .wb_o        (wb_o)
    );

    task automatic add_row(input lsq_pkg::mem_op_t op, input lsq_pkg::reg_addr_t rd,
                           input lsq_pkg::bus64_t rs1, input lsq_pkg::bus64_t rs2,
                           input lsq_pkg::bus64_t imm, input logic gap, input logic rnd);
        row_t r;
        r = '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm, gap: gap, flush: 1'b0, rnd: rnd};
        table_q.push_back(r);
    endtask

    task automatic add_flush();
        row_t r;
        r = '0;
        r.flush = 1'b1;
        table_q.push_back(r);
    endtask

    task automatic build_table();
        // Store then load, order and rd
        add_row(lsq_pkg::MEM_SD, 5'd1, 64'h40, 64'h1122_3344_5566_7788, 64'h0, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LD, 5'd2, 64'h40, 64'h0, 64'h0, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_SD, 5'd3, 64'h80, 64'hdead_beef_0bad_f00d, 64'h18, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LD, 5'd4, 64'h90, 64'h0, 64'h8, 1'b1, 1'b0);
        // Word halves, merge and sign extension
        add_row(lsq_pkg::MEM_SW, 5'd5, 64'h100, 64'h0000_0000_8123_4567, 64'h4, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_SW, 5'd6, 64'h100, 64'hffff_ffff_0765_4321, 64'h0, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LD, 5'd7, 64'h100, 64'h0, 64'h0, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LW, 5'd8, 64'h100, 64'h0, 64'h4, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LW, 5'd9, 64'h100, 64'h0, 64'h0, 1'b1, 1'b0);
        // Negative imm, then out of range accesses
        add_row(lsq_pkg::MEM_SD, 5'd10, 64'h60, 64'h0123_4567_89ab_cdef, -64'd8, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LD, 5'd11, 64'h50, 64'h0, 64'h8, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_SD, 5'd12, 64'h1f8, 64'hffff_0000_ffff_0000, 64'h10, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LW, 5'd13, 64'h200, 64'h0, 64'h0, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LD, 5'd14, 64'h400, 64'h0, -64'h1f8, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LD, 5'd15, 64'h0, 64'h0, 64'h8, 1'b1, 1'b0);  // Alias of 0x208
        // Back to back stores that fill the queue
        for (int i = 0; i < 16; i++) begin
            add_row(lsq_pkg::MEM_SD, 5'(i), 64'h180, 64'h0, 64'(8 * i), (i == 15), 1'b1);
        end
        add_row(lsq_pkg::MEM_LD, 5'd16, 64'h180, 64'h0, 64'h0, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LD, 5'd17, 64'h180, 64'h0, 64'h28, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LD, 5'd18, 64'h180, 64'h0, 64'h78, 1'b1, 1'b0);
        // Loads queued, then flushed
        for (int i = 0; i < 5; i++) begin
            add_row(lsq_pkg::MEM_LD, 5'(20 + i), 64'h180, 64'h0, 64'(8 * i), 1'b0, 1'b0);
        end
        add_flush();
        add_row(lsq_pkg::MEM_SD, 5'd25, 64'h1c0, 64'h8000_0001_7fff_fffe, 64'h0, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LD, 5'd26, 64'h1c0, 64'h0, 64'h0, 1'b0, 1'b0);
        add_row(lsq_pkg::MEM_LW, 5'd27, 64'h1c0, 64'h0, 64'h4, 1'b1, 1'b0);
    endtask

    // Expected writeback with the memory model updated in acceptance order
    task automatic predict(input row_t r, input lsq_pkg::bus64_t rs2);
        lsq_pkg::bus64_t     sum;
        lsq_pkg::paddr_t     addr;
        logic [5:0]          idx;
        logic [31:0]         half;
        lsq_pkg::wb_result_t e;
        sum  = r.rs1 + r.imm;
        addr = sum[11:0];               // APB address keeps 12 bits
        idx  = addr[8:3];
        e    = '0;
        e.valid    = 1'b1;
        e.rd       = r.rd;
        e.err      = (addr >= 12'd512);  // 64 doublewords
        e.is_store = (r.op == lsq_pkg::MEM_SD) || (r.op == lsq_pkg::MEM_SW);
        if (!e.err) begin
            half = addr[2] ? ref_mem[idx][63:32] : ref_mem[idx][31:0];
            case (r.op)
                lsq_pkg::MEM_SD: ref_mem[idx] = rs2;
                lsq_pkg::MEM_SW: begin
                    if (addr[2]) begin
                        ref_mem[idx][63:32] = rs2[31:0];
                    end else begin
                        ref_mem[idx][31:0] = rs2[31:0];
                    end
                end
                lsq_pkg::MEM_LD: e.data = ref_mem[idx];
                default:         e.data = {{32{half[31]}}, half};
            endcase
        end
        exp_q.push_back(e);
    endtask

    // One offer that counts as accepted only if full_o is low at the next edge
    task automatic offer_row(input row_t r);
        lsq_pkg::bus64_t rs2;
        rs2 = r.rs2;
        if (r.rnd) begin
            rs2 = {$random(seed), $random(seed)};
        end
        @(posedge clk_i);
        #1;
        entry           = '0;
        entry.instr.valid = 1'b1;
        entry.instr.op  = r.op;
        entry.instr.rd  = r.rd;
        entry.instr.imm = r.imm;
        entry.rs1       = r.rs1;
        entry.rs2       = rs2;
        #2;
        if (!full_o) begin
            predict(r, rs2);
            acc_cnt++;
        end else begin
            drop_cnt++;   // Offered while full
            saw_full = 1'b1;
        end
    endtask

    task automatic apply_flush();
        @(posedge clk_i);
        #1;
        entry = '0;
        flush = 1'b1;
        #2;
        compare_field("full_o", 64'(1'b1), 64'(full_o));  // Full during the flush cycle
        @(posedge clk_i);
        #1;
        flush = 1'b0;
        #2;
        assert (empty_o && flushed_cnt > 0) else begin
            other_errs++;
            $display("Flush left the queue non-empty or found nothing pending");
        end
    endtask

    // Stop offering and wait for all expected writebacks
    task automatic drain();
        @(posedge clk_i);
        #1;
        entry = '0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #3;
        end
        assert (empty_o) else begin
            other_errs++;
            $display("Queue not empty after all writebacks arrived");
        end
    endtask

    task automatic compare_field(input string name, input lsq_pkg::bus64_t exp_v,
                                 input lsq_pkg::bus64_t got_v);
        assert (exp_v == got_v) else begin
            val_errs++;
            $display("ERR %0t: %s expected %h got %h", $time, name, exp_v, got_v);
        end
    endtask

    // Writeback and tail index monitor at the falling edge where outputs are stable
    always @(negedge clk_i) begin
        if (rstn_i && wb_o.valid) begin
            wb_cnt++;
            assert (exp_q.size() != 0) else begin
                other_errs++;
                $display("Writeback for rd %0d arrived with nothing pending", wb_o.rd);
            end
            if (exp_q.size() != 0) begin
                exp_wb = exp_q.pop_front();
                compare_field("rd", 64'(exp_wb.rd), 64'(wb_o.rd));
                compare_field("is_store", 64'(exp_wb.is_store), 64'(wb_o.is_store));
                compare_field("err", 64'(exp_wb.err), 64'(wb_o.err));
                compare_field("data", exp_wb.data, wb_o.data);
            end
        end
        if (!rstn_i) begin
            tail_model = '0;
            idx_exp    = '0;
        end else begin
            compare_field("entry_idx", 64'(idx_exp), 64'(entry_idx));
            idx_exp = tail_model;
            if (flush) begin
                tail_model = '0;  // Flush rewinds the tail
            end else if (entry.instr.valid && !full_o) begin
                tail_model = tail_model + lsq_pkg::lsq_idx_t'(1);  // Wraps after the last slot
            end
        end
        if (flush) begin
            flushed_cnt += exp_q.size();  // Queued and in flight work dropped
            exp_q.delete();
        end
    end

    initial begin : stimulus
        entry = '0;
        flush = 1'b0;
        seed  = 32'he355_adad;
        for (int i = 0; i < lsq_pkg::MEM_WORDS; i++) begin
            ref_mem[i] = '0;  // Memory resets to zero
        end
        build_table();
        wait (rstn_i === 1'b1);
        @(posedge clk_i);
        #3;
        assert (!full_o && empty_o) else begin
            other_errs++;
            $display("Queue flags wrong after reset");
        end
        foreach (table_q[n]) begin
            if (table_q[n].flush) begin
                apply_flush();
            end else begin
                offer_row(table_q[n]);
                if (table_q[n].gap) begin
                    drain();
                end
            end
        end
        drain();
        repeat (8) @(posedge clk_i);   // Catch stray writebacks
        assert (saw_full && drop_cnt > 0) else begin
            other_errs++;
            $display("Back to back rows never filled the queue");
        end
        assert (wb_cnt + flushed_cnt == acc_cnt) else begin
            other_errs++;
            $display("Writeback count does not match accepted rows");
        end
        $display("Errors: value %0d, other %0d; accepted %0d, dropped %0d, wb %0d, flushed %0d",
                 val_errs, other_errs, acc_cnt, drop_cnt, wb_cnt, flushed_cnt);
        if (val_errs == 0 && other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Limit scales with the table length
    initial begin : watchdog
        int limit;
        wait (rstn_i === 1'b1);
        limit = table_q.size() * 40 + 200;
        repeat (limit) @(posedge clk_i);
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
common/lsq_pkg.sv
lsq/load_store_queue.sv
lsq/lsq_access_unit.sv
hdl/apb_data_mem.sv
hdl/mem_stage_top.sv
verif/tb_clock_gen.sv
verif/tb_mem_stage.sv

//--- Makefile
# Verilator build and run of the memory stage testbench

TOP := tb_mem_stage
SIM := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f flist.f
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" sim.log; then echo "Simulation gave no result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
